// File: dv/net_user_tb.sv
/*
 * Testbench for the network user shell. It checks reset state, send-queue
 * tagging and round robin, read/write routing under back-pressure and the
 * DDR offset on TCP memory commands against reference functions.
 */
`timescale 1ns/1ps

module net_user_tb
    import net_meta_pkg::*;
    import tcp_mem_pkg::*;
();

    localparam int N_REGIONS = 4;
    localparam int N_STAGES = 2;
    localparam int CLK_PERIOD = 20;
    localparam int IDX_BITS = $clog2(N_REGIONS);
    localparam int SQ_TAGGED = RDMA_SQ_BITS + REGION_ID_MAX_BITS;
    localparam int REQ_TAGGED = RDMA_REQ_BITS + REGION_ID_MAX_BITS;
    localparam int SQ_PER_REGION = 16;
    localparam int RR_PER_REGION = 12;
    localparam int REQ_ITEMS = 64;
    localparam int CMD_ITEMS = 20;
    // Worst cycles per item under random ready and contention
    localparam int STALL_CYCLES = 4 * N_REGIONS;
    localparam int TOTAL_ITEMS = N_REGIONS * (SQ_PER_REGION + RR_PER_REGION)
                                 + 2 * REQ_ITEMS + 2 * CMD_ITEMS;
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * STALL_CYCLES + 500;

    logic aclk = 1'b0;
    logic aresetn;
    logic [N_REGIONS-1:0]                    s_rdma_sq_valid;
    logic [N_REGIONS-1:0]                    s_rdma_sq_ready;
    logic [N_REGIONS-1:0][RDMA_SQ_BITS-1:0]  s_rdma_sq_data;
    logic                                    m_rdma_sq_net_valid;
    logic                                    m_rdma_sq_net_ready;
    logic [SQ_TAGGED-1:0]                    m_rdma_sq_net_data;
    logic                                    s_rdma_rd_req_net_valid;
    logic                                    s_rdma_rd_req_net_ready;
    logic [REQ_TAGGED-1:0]                   s_rdma_rd_req_net_data;
    logic [N_REGIONS-1:0]                    m_rdma_rd_req_valid;
    logic [N_REGIONS-1:0]                    m_rdma_rd_req_ready;
    logic [N_REGIONS-1:0][RDMA_REQ_BITS-1:0] m_rdma_rd_req_data;
    logic                                    s_rdma_wr_req_net_valid;
    logic                                    s_rdma_wr_req_net_ready;
    logic [REQ_TAGGED-1:0]                   s_rdma_wr_req_net_data;
    logic [N_REGIONS-1:0]                    m_rdma_wr_req_valid;
    logic [N_REGIONS-1:0]                    m_rdma_wr_req_ready;
    logic [N_REGIONS-1:0][RDMA_REQ_BITS-1:0] m_rdma_wr_req_data;
    logic [MEM_ADDR_BITS-1:0]                ddr_offset_addr;
    logic                                    s_tcp_mem_cmd_valid;
    logic                                    s_tcp_mem_cmd_ready;
    logic [TCP_MEM_CMD_BITS-1:0]             s_tcp_mem_cmd_data;
    logic                                    m_tcp_mem_cmd_valid;
    logic                                    m_tcp_mem_cmd_ready;
    logic [TCP_MEM_CMD_BITS-1:0]             m_tcp_mem_cmd_data;

    integer seed = 32'h13e3d964;
    logic rand_ready;
    logic sq_hold;
    logic rr_active;
    logic [MEM_ADDR_BITS-1:0] cur_offset;
    string sq_test;

    // Expected items are pushed at input handshakes
    logic [RDMA_SQ_BITS-1:0]     sq_exp_q [N_REGIONS][$];
    logic [RDMA_REQ_BITS-1:0]    rd_exp_q [N_REGIONS][$];
    logic [RDMA_REQ_BITS-1:0]    wr_exp_q [N_REGIONS][$];
    logic [TCP_MEM_CMD_BITS-1:0] cmd_exp_q [$];
    int rr_tags [$];

    net_user_top #(.N_REGIONS(N_REGIONS), .N_STAGES(N_STAGES)) net_user_top_inst (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    function automatic logic [SQ_TAGGED-1:0] tag_sq(input int region,
                                                     input logic [RDMA_SQ_BITS-1:0] entry);
        return {REGION_ID_MAX_BITS'(region), entry};
    endfunction

    function automatic logic [REQ_TAGGED-1:0] tag_req(input int region,
                                                       input logic [RDMA_REQ_BITS-1:0] req);
        return {REGION_ID_MAX_BITS'(region), req};
    endfunction

    function automatic logic [RDMA_REQ_BITS-1:0] untag_req(input logic [REQ_TAGGED-1:0] word);
        return word[RDMA_REQ_BITS-1:0];
    endfunction

    function automatic int req_region(input logic [REQ_TAGGED-1:0] word);
        return int'(word[RDMA_REQ_BITS +: REGION_ID_MAX_BITS]);
    endfunction

    // Address plus offset wraps at 2^64 and the length passes unchanged
    function automatic logic [TCP_MEM_CMD_BITS-1:0] offset_sum(
        input logic [TCP_MEM_CMD_BITS-1:0] cmd, input logic [MEM_ADDR_BITS-1:0] offset);
        return {cmd[TCP_MEM_CMD_BITS-1:MEM_ADDR_BITS], cmd[MEM_ADDR_BITS-1:0] + offset};
    endfunction

    function automatic int rr_next(input int region);
        return (region + 1) % N_REGIONS;
    endfunction

    function automatic bit queues_empty();
        for (int i = 0; i < N_REGIONS; i++) begin
            if (sq_exp_q[i].size() != 0 || rd_exp_q[i].size() != 0 || wr_exp_q[i].size() != 0)
                return 1'b0;
        end
        return cmd_exp_q.size() == 0;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_reset_outputs();
        assert (!m_rdma_sq_net_valid && m_rdma_rd_req_valid == '0 &&
                m_rdma_wr_req_valid == '0 && !m_tcp_mem_cmd_valid)
            else fail_run("a valid output is high during or right after reset");
        assert (&s_rdma_sq_ready && s_rdma_rd_req_net_ready && s_rdma_wr_req_net_ready &&
                s_tcp_mem_cmd_ready)
            else fail_run("a ready output is low during or right after reset");
    endtask

    task automatic run_sq_region(input int region, input int count, input bit gaps);
        logic [RDMA_SQ_BITS-1:0] entry;
        for (int k = 0; k < count; k++) begin
            if (gaps) begin
                repeat ($unsigned($random(seed)) % 3) begin
                    @(posedge aclk);
                    #2;
                end
            end
            entry = {$random(seed), $random(seed)};
            s_rdma_sq_data[region] = entry;
            s_rdma_sq_valid[region] = 1'b1;
            do @(posedge aclk); while (!s_rdma_sq_ready[region]);
            #2;
            s_rdma_sq_valid[region] = 1'b0;
        end
    endtask

    task automatic run_req_stream(input bit wr, input int count);
        logic [RDMA_REQ_BITS-1:0] body;
        int region;
        for (int k = 0; k < count; k++) begin
            body = {$random(seed), $random(seed), $random(seed)};
            region = $unsigned($random(seed)) % N_REGIONS;
            if (wr) begin
                s_rdma_wr_req_net_data = tag_req(region, body);
                s_rdma_wr_req_net_valid = 1'b1;
                do @(posedge aclk); while (!s_rdma_wr_req_net_ready);
                #2;
                s_rdma_wr_req_net_valid = 1'b0;
            end else begin
                s_rdma_rd_req_net_data = tag_req(region, body);
                s_rdma_rd_req_net_valid = 1'b1;
                do @(posedge aclk); while (!s_rdma_rd_req_net_ready);
                #2;
                s_rdma_rd_req_net_valid = 1'b0;
            end
        end
    endtask

    task automatic run_cmds(input int count);
        logic [95:0] raw;
        for (int k = 0; k < count; k++) begin
            raw = {$random(seed), $random(seed), $random(seed)};
            s_tcp_mem_cmd_data = raw[TCP_MEM_CMD_BITS-1:0];
            s_tcp_mem_cmd_valid = 1'b1;
            do @(posedge aclk); while (!s_tcp_mem_cmd_ready);
            #2;
            s_tcp_mem_cmd_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        while (!queues_empty()) begin
            @(posedge aclk);
            #2;
        end
    endtask

    // Each output tag follows the one before it in round-robin order
    task automatic check_rr_order();
        assert (rr_tags.size() > 2 * N_REGIONS)
            else fail_run("too few send-queue outputs during the round-robin run");
        for (int k = 1; k < rr_tags.size(); k++) begin
            assert (rr_tags[k] == rr_next(rr_tags[k-1]))
                else report_mismatch("round_robin", 128'(rr_next(rr_tags[k-1])),
                                     128'(rr_tags[k]));
        end
    endtask

    task automatic compare_outputs();
        logic [IDX_BITS-1:0]         tag;
        logic [SQ_TAGGED-1:0]        exp_sq;
        logic [RDMA_REQ_BITS-1:0]    exp_req;
        logic [TCP_MEM_CMD_BITS-1:0] exp_cmd;
        if (m_rdma_sq_net_valid && m_rdma_sq_net_ready) begin
            tag = m_rdma_sq_net_data[RDMA_SQ_BITS +: IDX_BITS];
            assert (m_rdma_sq_net_data[SQ_TAGGED-1:RDMA_SQ_BITS] < N_REGIONS &&
                    sq_exp_q[tag].size() > 0)
                else fail_run("send-queue output with no pending entry for its tag");
            exp_sq = tag_sq(int'(tag), sq_exp_q[tag].pop_front());
            assert (m_rdma_sq_net_data == exp_sq)
                else report_mismatch(sq_test, 128'(exp_sq), 128'(m_rdma_sq_net_data));
            if (rr_active)
                rr_tags.push_back(int'(tag));
        end
        for (int i = 0; i < N_REGIONS; i++) begin
            if (m_rdma_rd_req_valid[i] && m_rdma_rd_req_ready[i]) begin
                assert (rd_exp_q[i].size() > 0)
                    else fail_run("read request reached a region with none pending");
                exp_req = rd_exp_q[i].pop_front();
                assert (m_rdma_rd_req_data[i] == exp_req)
                    else report_mismatch("rd_routing", 128'(exp_req),
                                         128'(m_rdma_rd_req_data[i]));
            end
            if (m_rdma_wr_req_valid[i] && m_rdma_wr_req_ready[i]) begin
                assert (wr_exp_q[i].size() > 0)
                    else fail_run("write request reached a region with none pending");
                exp_req = wr_exp_q[i].pop_front();
                assert (m_rdma_wr_req_data[i] == exp_req)
                    else report_mismatch("wr_routing", 128'(exp_req),
                                         128'(m_rdma_wr_req_data[i]));
            end
        end
        if (m_tcp_mem_cmd_valid && m_tcp_mem_cmd_ready) begin
            assert (cmd_exp_q.size() > 0)
                else fail_run("memory command output with none pending");
            exp_cmd = cmd_exp_q.pop_front();
            assert (m_tcp_mem_cmd_data == exp_cmd)
                else report_mismatch("mem_offset", 128'(exp_cmd), 128'(m_tcp_mem_cmd_data));
        end
    endtask

    task automatic capture_inputs();
        for (int i = 0; i < N_REGIONS; i++) begin
            if (s_rdma_sq_valid[i] && s_rdma_sq_ready[i])
                sq_exp_q[i].push_back(s_rdma_sq_data[i]);
        end
        if (s_rdma_rd_req_net_valid && s_rdma_rd_req_net_ready)
            rd_exp_q[req_region(s_rdma_rd_req_net_data)].push_back(
                untag_req(s_rdma_rd_req_net_data));
        if (s_rdma_wr_req_net_valid && s_rdma_wr_req_net_ready)
            wr_exp_q[req_region(s_rdma_wr_req_net_data)].push_back(
                untag_req(s_rdma_wr_req_net_data));
        if (s_tcp_mem_cmd_valid && s_tcp_mem_cmd_ready)
            cmd_exp_q.push_back(offset_sum(s_tcp_mem_cmd_data, cur_offset));
    endtask

    // Outputs are popped before inputs are pushed on the same edge
    always @(posedge aclk) begin
        if (aresetn) begin
            compare_outputs();
            capture_inputs();
        end
    end

    // Output-side ready is either random or steady
    initial begin
        forever begin
            @(posedge aclk);
            #2;
            if (rand_ready) begin
                m_rdma_sq_net_ready = 1'($random(seed));
                m_rdma_rd_req_ready = N_REGIONS'($random(seed));
                m_rdma_wr_req_ready = N_REGIONS'($random(seed));
                m_tcp_mem_cmd_ready = 1'($random(seed));
            end else begin
                m_rdma_sq_net_ready = !sq_hold;
                m_rdma_rd_req_ready = '1;
                m_rdma_wr_req_ready = '1;
                m_tcp_mem_cmd_ready = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("timeout waiting for outputs");
    end

    initial begin
        aresetn = 1'b0;
        s_rdma_sq_valid = '0;
        s_rdma_sq_data = '0;
        m_rdma_sq_net_ready = 1'b1;
        s_rdma_rd_req_net_valid = 1'b0;
        s_rdma_rd_req_net_data = '0;
        m_rdma_rd_req_ready = '1;
        s_rdma_wr_req_net_valid = 1'b0;
        s_rdma_wr_req_net_data = '0;
        m_rdma_wr_req_ready = '1;
        ddr_offset_addr = '0;
        s_tcp_mem_cmd_valid = 1'b0;
        s_tcp_mem_cmd_data = '0;
        m_tcp_mem_cmd_ready = 1'b1;
        cur_offset = '0;
        rand_ready = 1'b0;
        sq_hold = 1'b0;
        rr_active = 1'b0;
        sq_test = "sq_tagging";

        repeat (10) begin
            @(posedge aclk);
            #2;
            check_reset_outputs();
        end
        aresetn = 1'b1;
        @(posedge aclk);
        #2;
        check_reset_outputs();

        // Random entries per region under random net ready
        rand_ready = 1'b1;
        for (int r = 0; r < N_REGIONS; r++) begin
            fork
                automatic int region = r;
                run_sq_region(region, SQ_PER_REGION, 1'b1);
            join_none
        end
        wait fork;
        wait_drained();

        // All regions busy while net ready is held off until the slices fill
        sq_test = "round_robin";
        rand_ready = 1'b0;
        sq_hold = 1'b1;
        for (int r = 0; r < N_REGIONS; r++) begin
            fork
                automatic int region = r;
                run_sq_region(region, RR_PER_REGION, 1'b0);
            join_none
        end
        repeat (10) begin
            @(posedge aclk);
            #2;
        end
        sq_hold = 1'b0;
        rr_active = 1'b1;
        wait fork;
        rr_active = 1'b0;
        wait_drained();
        check_rr_order();

        // Read and write routers side by side
        rand_ready = 1'b1;
        fork
            run_req_stream(1'b0, REQ_ITEMS);
            run_req_stream(1'b1, REQ_ITEMS);
        join
        wait_drained();

        // Each of two offsets settles past the delay line first
        for (int pass = 0; pass < 2; pass++) begin
            cur_offset = {$random(seed), $random(seed)};
            ddr_offset_addr = cur_offset;
            repeat (N_STAGES + 3) begin
                @(posedge aclk);
                #2;
            end
            run_cmds(CMD_ITEMS);
            wait_drained();
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: net_user_top.f
src/net_meta_pkg.sv
src/tcp_mem_pkg.sv
src/meta_slice_array.sv
src/rdma_sq_arbiter.sv
src/rdma_req_router.sv
src/tcp_mem_cmd_offset.sv
src/net_user_top.sv
dv/net_user_tb.sv

// File: src/meta_slice_array.sv
/*
 * Chain of register slices for one valid/ready metadata stream.
 * Each stage is a two-entry skid buffer, so the chain runs at one item
 * per cycle with N_STAGES cycles of latency and registered ready.
 */
`timescale 1ns/1ps

module meta_slice_array #(
    parameter int WIDTH = 64,
    parameter int N_STAGES = 2
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             s_valid,
    output logic             s_ready,
    input  logic [WIDTH-1:0] s_data,
    output logic             m_valid,
    input  logic             m_ready,
    output logic [WIDTH-1:0] m_data
);

    // Stage k reads index k and drives index k+1
    logic [N_STAGES:0] chain_valid;
    logic [N_STAGES:0] chain_ready;
    logic [WIDTH-1:0]  chain_data [N_STAGES+1];

    assign chain_valid[0] = s_valid;
    assign chain_data[0] = s_data;
    assign s_ready = chain_ready[0];

    assign m_valid = chain_valid[N_STAGES];
    assign m_data = chain_data[N_STAGES];
    assign chain_ready[N_STAGES] = m_ready;

    for (genvar k = 0; k < N_STAGES; k++) begin : g_stage
        logic             main_valid;
        logic [WIDTH-1:0] main_data;
        logic             spare_valid;
        logic [WIDTH-1:0] spare_data;
        logic             main_free;

        // Main entry can take a new item when empty or leaving
        assign main_free = !main_valid || chain_ready[k+1];

        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                main_valid <= 1'b0;
                spare_valid <= 1'b0;
            end else if (main_free) begin
                main_valid <= spare_valid || chain_valid[k];
                spare_valid <= 1'b0;
            end else if (chain_valid[k] && !spare_valid) begin
                // Output stalled, park the incoming item
                spare_valid <= 1'b1;
            end
        end

        always_ff @(posedge aclk) begin
            if (main_free) begin
                main_data <= spare_valid ? spare_data : chain_data[k];
            end
            if (!spare_valid) begin
                spare_data <= chain_data[k];
            end
        end

        assign chain_ready[k] = !spare_valid;
        assign chain_valid[k+1] = main_valid;
        assign chain_data[k+1] = main_data;
    end

    // Stalled output holds its item
    assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

// File: src/net_meta_pkg.sv
/*
 * Field widths of the RDMA metadata words that cross the user shell.
 * Send-queue entries and read/write requests travel as plain words; the
 * network side adds a region tag above them. Imported by the RDMA blocks
 * and the top level.
 */
package net_meta_pkg;

    // One user send-queue entry (opcode, address, length)
    localparam int RDMA_SQ_BITS = 64;

    // One read or write request as a region sees it
    localparam int RDMA_REQ_BITS = 96;

    // Widest region tag on the network side.
    // Only the low $clog2(N_REGIONS) bits select a region.
    localparam int REGION_ID_MAX_BITS = 4;

endpackage

// File: src/net_user_top.sv
/*
 * User-side shell of the network stack in the aclk domain.
 * Send queues are sliced per region and merged by round robin; read and
 * write requests are routed per region and sliced; TCP memory commands
 * get the delayed DDR offset added.
 */
`timescale 1ns/1ps

module net_user_top
    import net_meta_pkg::*;
    import tcp_mem_pkg::*;
#(
    parameter int N_REGIONS = 4,
    parameter int N_STAGES = 2
) (
    input  logic                                        aclk,
    input  logic                                        aresetn,

    // Send queues from the regions, merged toward the network
    input  logic [N_REGIONS-1:0]                        s_rdma_sq_valid,
    output logic [N_REGIONS-1:0]                        s_rdma_sq_ready,
    input  logic [N_REGIONS-1:0][RDMA_SQ_BITS-1:0]      s_rdma_sq_data,
    output logic                                        m_rdma_sq_net_valid,
    input  logic                                        m_rdma_sq_net_ready,
    output logic [RDMA_SQ_BITS+REGION_ID_MAX_BITS-1:0]  m_rdma_sq_net_data,

    // Read requests
    input  logic                                        s_rdma_rd_req_net_valid,
    output logic                                        s_rdma_rd_req_net_ready,
    input  logic [RDMA_REQ_BITS+REGION_ID_MAX_BITS-1:0] s_rdma_rd_req_net_data,
    output logic [N_REGIONS-1:0]                        m_rdma_rd_req_valid,
    input  logic [N_REGIONS-1:0]                        m_rdma_rd_req_ready,
    output logic [N_REGIONS-1:0][RDMA_REQ_BITS-1:0]     m_rdma_rd_req_data,

    // Write requests
    input  logic                                        s_rdma_wr_req_net_valid,
    output logic                                        s_rdma_wr_req_net_ready,
    input  logic [RDMA_REQ_BITS+REGION_ID_MAX_BITS-1:0] s_rdma_wr_req_net_data,
    output logic [N_REGIONS-1:0]                        m_rdma_wr_req_valid,
    input  logic [N_REGIONS-1:0]                        m_rdma_wr_req_ready,
    output logic [N_REGIONS-1:0][RDMA_REQ_BITS-1:0]     m_rdma_wr_req_data,

    // TCP memory commands
    input  logic [MEM_ADDR_BITS-1:0]                    ddr_offset_addr,
    input  logic                                        s_tcp_mem_cmd_valid,
    output logic                                        s_tcp_mem_cmd_ready,
    input  logic [TCP_MEM_CMD_BITS-1:0]                 s_tcp_mem_cmd_data,
    output logic                                        m_tcp_mem_cmd_valid,
    input  logic                                        m_tcp_mem_cmd_ready,
    output logic [TCP_MEM_CMD_BITS-1:0]                 m_tcp_mem_cmd_data
);

    logic [N_REGIONS-1:0]                   sq_slice_valid;
    logic [N_REGIONS-1:0]                   sq_slice_ready;
    logic [N_REGIONS-1:0][RDMA_SQ_BITS-1:0] sq_slice_data;

    // Router outputs, one data word shared by all regions
    logic [N_REGIONS-1:0]     rd_route_valid;
    logic [N_REGIONS-1:0]     rd_route_ready;
    logic [RDMA_REQ_BITS-1:0] rd_route_data;
    logic [N_REGIONS-1:0]     wr_route_valid;
    logic [N_REGIONS-1:0]     wr_route_ready;
    logic [RDMA_REQ_BITS-1:0] wr_route_data;

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_sq_slice
        meta_slice_array #(.WIDTH(RDMA_SQ_BITS), .N_STAGES(N_STAGES)) sq_slice_inst (
            .aclk(aclk), .aresetn(aresetn),
            .s_valid(s_rdma_sq_valid[i]), .s_ready(s_rdma_sq_ready[i]),
            .s_data(s_rdma_sq_data[i]),
            .m_valid(sq_slice_valid[i]), .m_ready(sq_slice_ready[i]),
            .m_data(sq_slice_data[i])
        );
    end

    rdma_sq_arbiter #(.N_REGIONS(N_REGIONS)) sq_arbiter_inst (
        .aclk(aclk), .aresetn(aresetn),
        .s_sq_valid(sq_slice_valid), .s_sq_ready(sq_slice_ready), .s_sq_data(sq_slice_data),
        .m_sq_valid(m_rdma_sq_net_valid), .m_sq_ready(m_rdma_sq_net_ready),
        .m_sq_data(m_rdma_sq_net_data)
    );

    rdma_req_router #(.N_REGIONS(N_REGIONS)) rd_router_inst (
        .aclk(aclk), .aresetn(aresetn),
        .s_req_valid(s_rdma_rd_req_net_valid), .s_req_ready(s_rdma_rd_req_net_ready),
        .s_req_data(s_rdma_rd_req_net_data),
        .m_req_valid(rd_route_valid), .m_req_ready(rd_route_ready),
        .m_req_data(rd_route_data)
    );

    rdma_req_router #(.N_REGIONS(N_REGIONS)) wr_router_inst (
        .aclk(aclk), .aresetn(aresetn),
        .s_req_valid(s_rdma_wr_req_net_valid), .s_req_ready(s_rdma_wr_req_net_ready),
        .s_req_data(s_rdma_wr_req_net_data),
        .m_req_valid(wr_route_valid), .m_req_ready(wr_route_ready),
        .m_req_data(wr_route_data)
    );

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_rd_slice
        meta_slice_array #(.WIDTH(RDMA_REQ_BITS), .N_STAGES(N_STAGES)) rd_slice_inst (
            .aclk(aclk), .aresetn(aresetn),
            .s_valid(rd_route_valid[i]), .s_ready(rd_route_ready[i]), .s_data(rd_route_data),
            .m_valid(m_rdma_rd_req_valid[i]), .m_ready(m_rdma_rd_req_ready[i]),
            .m_data(m_rdma_rd_req_data[i])
        );
    end

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_wr_slice
        meta_slice_array #(.WIDTH(RDMA_REQ_BITS), .N_STAGES(N_STAGES)) wr_slice_inst (
            .aclk(aclk), .aresetn(aresetn),
            .s_valid(wr_route_valid[i]), .s_ready(wr_route_ready[i]), .s_data(wr_route_data),
            .m_valid(m_rdma_wr_req_valid[i]), .m_ready(m_rdma_wr_req_ready[i]),
            .m_data(m_rdma_wr_req_data[i])
        );
    end

    tcp_mem_cmd_offset #(.N_STAGES(N_STAGES)) mem_cmd_offset_inst (
        .aclk(aclk), .aresetn(aresetn),
        .ddr_offset_addr(ddr_offset_addr),
        .s_cmd_valid(s_tcp_mem_cmd_valid), .s_cmd_ready(s_tcp_mem_cmd_ready),
        .s_cmd_data(s_tcp_mem_cmd_data),
        .m_cmd_valid(m_tcp_mem_cmd_valid), .m_cmd_ready(m_tcp_mem_cmd_ready),
        .m_cmd_data(m_tcp_mem_cmd_data)
    );

endmodule

// File: src/rdma_req_router.sv
/*
 * Steers tagged RDMA requests from the network to the region in the tag.
 * One output register is shared by all regions; only the target sees valid.
 * A stalled target region holds the register and so blocks the input.
 */
`timescale 1ns/1ps

module rdma_req_router
    import net_meta_pkg::*;
#(
    parameter int N_REGIONS = 4
) (
    input  logic                                         aclk,
    input  logic                                         aresetn,
    input  logic                                         s_req_valid,
    output logic                                         s_req_ready,
    input  logic [RDMA_REQ_BITS+REGION_ID_MAX_BITS-1:0]  s_req_data,
    output logic [N_REGIONS-1:0]                         m_req_valid,
    input  logic [N_REGIONS-1:0]                         m_req_ready,
    output logic [RDMA_REQ_BITS-1:0]                     m_req_data
);

    localparam int IDX_BITS = $clog2(N_REGIONS);

    logic [REGION_ID_MAX_BITS-1:0] in_tag;
    logic                          hold_valid;
    logic [N_REGIONS-1:0]          hold_target;
    logic                          drain;

    assign in_tag = s_req_data[RDMA_REQ_BITS +: REGION_ID_MAX_BITS];

    // Held request leaves when its own region takes it
    assign drain = hold_valid && |(hold_target & m_req_ready);
    assign s_req_ready = !hold_valid || drain;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hold_valid <= 1'b0;
        end else if (s_req_ready) begin
            hold_valid <= s_req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_req_valid && s_req_ready) begin
            hold_target <= N_REGIONS'(1) << in_tag[IDX_BITS-1:0];
            m_req_data <= s_req_data[RDMA_REQ_BITS-1:0];
        end
    end

    assign m_req_valid = {N_REGIONS{hold_valid}} & hold_target;

    assert property (@(posedge aclk) disable iff (!aresetn)
        s_req_valid && s_req_ready |-> in_tag < N_REGIONS);

endmodule

// File: src/rdma_sq_arbiter.sv
/*
 * Round-robin merge of the per-region RDMA send queues toward the network.
 * The winning entry is registered with its region number as tag above it.
 * Search starts one past the last grant.
 */
`timescale 1ns/1ps

module rdma_sq_arbiter
    import net_meta_pkg::*;
#(
    parameter int N_REGIONS = 4
) (
    input  logic                                         aclk,
    input  logic                                         aresetn,
    input  logic [N_REGIONS-1:0]                         s_sq_valid,
    output logic [N_REGIONS-1:0]                         s_sq_ready,
    input  logic [N_REGIONS-1:0][RDMA_SQ_BITS-1:0]       s_sq_data,
    output logic                                         m_sq_valid,
    input  logic                                         m_sq_ready,
    output logic [RDMA_SQ_BITS+REGION_ID_MAX_BITS-1:0]   m_sq_data
);

    localparam int IDX_BITS = $clog2(N_REGIONS);

    logic [IDX_BITS-1:0] rr_ptr;
    logic [IDX_BITS-1:0] cand;
    logic [IDX_BITS-1:0] grant_idx;
    logic                found;
    logic                load;

    // First pending region at or after the pointer with wraparound
    always_comb begin
        found = 1'b0;
        grant_idx = rr_ptr;
        cand = rr_ptr;
        for (int k = 0; k < N_REGIONS; k++) begin
            cand = rr_ptr + IDX_BITS'(k);
            if (!found && s_sq_valid[cand]) begin
                found = 1'b1;
                grant_idx = cand;
            end
        end
    end

    assign load = found && (!m_sq_valid || m_sq_ready);

    always_comb begin
        s_sq_ready = '0;
        s_sq_ready[grant_idx] = load;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_sq_valid <= 1'b0;
            rr_ptr <= '0;
        end else if (load) begin
            m_sq_valid <= 1'b1;
            rr_ptr <= grant_idx + 1'b1;
        end else if (m_sq_ready) begin
            m_sq_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            m_sq_data <= {REGION_ID_MAX_BITS'(grant_idx), s_sq_data[grant_idx]};
        end
    end

    // A pending region that lost the grant keeps its request up
    assert property (@(posedge aclk) disable iff (!aresetn)
        ($past(s_sq_valid & ~s_sq_ready) & ~s_sq_valid) == '0);

endmodule

// File: src/tcp_mem_cmd_offset.sv
/*
 * Adds the DDR base offset to the address of each TCP memory command.
 * The offset input passes an N_STAGES register delay first.
 * Output is registered with a spare entry for full throughput.
 */
`timescale 1ns/1ps

module tcp_mem_cmd_offset
    import tcp_mem_pkg::*;
#(
    parameter int N_STAGES = 2
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic [MEM_ADDR_BITS-1:0]    ddr_offset_addr,
    input  logic                        s_cmd_valid,
    output logic                        s_cmd_ready,
    input  logic [TCP_MEM_CMD_BITS-1:0] s_cmd_data,
    output logic                        m_cmd_valid,
    input  logic                        m_cmd_ready,
    output logic [TCP_MEM_CMD_BITS-1:0] m_cmd_data
);

    logic [MEM_ADDR_BITS-1:0]    offset_q [N_STAGES];
    logic [TCP_MEM_CMD_BITS-1:0] cmd_sum;
    logic                        spare_valid;
    logic [TCP_MEM_CMD_BITS-1:0] spare_data;
    logic                        main_free;

    always_ff @(posedge aclk) begin
        offset_q[0] <= ddr_offset_addr;
        for (int i = 1; i < N_STAGES; i++) begin
            offset_q[i] <= offset_q[i-1];
        end
    end

    // Length untouched, address wraps at 2^64
    assign cmd_sum = {s_cmd_data[MEM_LEN_LSB +: MEM_LEN_BITS],
                      s_cmd_data[MEM_ADDR_BITS-1:0] + offset_q[N_STAGES-1]};

    assign main_free = !m_cmd_valid || m_cmd_ready;
    assign s_cmd_ready = !spare_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_cmd_valid <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_free) begin
            m_cmd_valid <= spare_valid || s_cmd_valid;
            spare_valid <= 1'b0;
        end else if (s_cmd_valid && !spare_valid) begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (main_free) begin
            m_cmd_data <= spare_valid ? spare_data : cmd_sum;
        end
        if (!spare_valid) begin
            spare_data <= cmd_sum;
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_cmd_valid && !m_cmd_ready |=> m_cmd_valid && $stable(m_cmd_data));

endmodule

// File: src/tcp_mem_pkg.sv
/*
 * Layout of the TCP memory command word sent toward DDR.
 * Address sits in the low bits, length right above it.
 * Imported by the offset block and the top level.
 */
package tcp_mem_pkg;

    // Address field, starts at bit 0
    localparam int MEM_ADDR_BITS = 64;

    // Length field
    localparam int MEM_LEN_BITS = 23;
    localparam int MEM_LEN_LSB = MEM_ADDR_BITS;

    // Whole command word
    localparam int TCP_MEM_CMD_BITS = MEM_ADDR_BITS + MEM_LEN_BITS;

endpackage
